//--- ntt_gf64_macros.svh
/*
 * Global constants for the GF64 NTT pipeline.
 * Coefficient width, lanes per beat, batch id width,
 * Goldilocks prime, 4th root of unity shift and error vector width
 */
`ifndef NTT_GF64_MACROS_SVH
`define NTT_GF64_MACROS_SVH

// Field element width
`define NTT_MOD_W     64

// Radix, one butterfly pair per two lanes
`define NTT_R         4

`define NTT_PBS_ID_W  4

// p = 2^64 - 2^32 + 1
`define NTT_PRIME     64'hFFFF_FFFF_0000_0001

// w_4 = 2^48, so the twiddle is a plain shift
`define NTT_W4_SHIFT  48

`define NTT_ERR_W     2

`endif

//--- ntt_gf64_pkg.sv
/*
 * Types for the GF64 NTT pipeline: coefficients, control and beat structs,
 * error vector and framing FSM states. Modular add, sub, power-of-two
 * multiply and product folding for the Goldilocks prime.
 */
`default_nettype none

`include "ntt_gf64_macros.svh"

package ntt_gf64_pkg;

  typedef logic [`NTT_MOD_W-1:0]   coef_t;     // Canonical or partially reduced
  typedef coef_t [`NTT_R-1:0]      coef_vec_t; // One beat worth of lanes
  typedef logic [2*`NTT_MOD_W-1:0] prod_t;     // Raw product before folding
  typedef logic [`NTT_ERR_W-1:0]   ntt_err_t;

  typedef struct packed {
    logic                     sob;
    logic                     eob;
    logic [`NTT_PBS_ID_W-1:0] pbs_id;
  } ntt_ctrl_t;

  typedef struct packed {
    logic      avail;
    ntt_ctrl_t ctrl;
    coef_vec_t data;
  } ntt_beat_t;

  typedef enum logic {
    FRAME_IDLE     = 1'b0,
    FRAME_IN_BATCH = 1'b1
  } frame_state_e;

  // Error vector bit positions
  localparam int ERR_KEY_MISS = 0;
  localparam int ERR_FRAMING  = 1;

  // 2^64 mod p, i.e. 2^32 - 1
  localparam coef_t FOLD_EPS = 64'd0 - `NTT_PRIME;

  // --------------------
  // Modular arithmetic
  // --------------------
  function automatic coef_t mod_add(input coef_t a, input coef_t b);
    logic [`NTT_MOD_W:0] s;
    s = {1'b0, a} + {1'b0, b};
    if (s >= {1'b0, `NTT_PRIME}) begin
      s = s - {1'b0, `NTT_PRIME};
    end
    return s[`NTT_MOD_W-1:0];
  endfunction

  // Wraps through 2^64 when a < b, result lands back below p
  function automatic coef_t mod_sub(input coef_t a, input coef_t b);
    return (a >= b) ? a - b : a - b + `NTT_PRIME;
  endfunction

  // x = hi*2^96 + mid*2^64 + lo  ->  lo - hi + mid*(2^32 - 1)
  // Result is below 2^64 but may still be >= p
  function automatic coef_t mod_fold_prod(input prod_t x);
    coef_t               lo;
    logic [31:0]         mid;
    logic [31:0]         hi;
    logic [`NTT_MOD_W:0] diff;
    coef_t               t0;
    coef_t               t1;
    logic [`NTT_MOD_W:0] sum;
    lo   = x[63:0];
    mid  = x[95:64];
    hi   = x[127:96];
    diff = {1'b0, lo} - {33'd0, hi};
    t0   = diff[`NTT_MOD_W] ? diff[`NTT_MOD_W-1:0] - FOLD_EPS : diff[`NTT_MOD_W-1:0];
    t1   = mid * FOLD_EPS;                 // At most (2^32-1)^2, no overflow
    sum  = {1'b0, t0} + {1'b0, t1};
    return sum[`NTT_MOD_W] ? sum[`NTT_MOD_W-1:0] + FOLD_EPS : sum[`NTT_MOD_W-1:0];
  endfunction

  // a * 2^k with k below 64, canonical result
  function automatic coef_t mod_shift_mul(input coef_t a, input int unsigned k);
    prod_t x;
    coef_t r;
    x = prod_t'(a) << k;
    r = mod_fold_prod(x);
    return (r >= `NTT_PRIME) ? r - `NTT_PRIME : r;
  endfunction

  // All lanes below p
  function automatic logic vec_is_canon(input coef_vec_t v);
    logic ok;
    ok = 1'b1;
    for (int i = 0; i < `NTT_R; i++) begin
      ok &= (v[i] < `NTT_PRIME);
    end
    return ok;
  endfunction

endpackage

`default_nettype wire

//--- ntt_gf64_in_decode.sv
/*
 * Input stage: registers the incoming beat with its control struct
 * and checks batch framing with a small FSM
 */
`timescale 1ns/1ps
`default_nettype none

`include "ntt_gf64_macros.svh"

module ntt_gf64_in_decode (
  input  logic                     clk,
  input  logic                     rst_n_i,
  input  logic                     in_avail_i,
  input  logic                     in_sob_i,
  input  logic                     in_eob_i,
  input  logic [`NTT_PBS_ID_W-1:0] in_pbs_id_i,
  input  ntt_gf64_pkg::coef_vec_t  in_data_i,
  output ntt_gf64_pkg::ntt_beat_t  out_beat_o,
  output logic                     frame_err_o
);
  import ntt_gf64_pkg::*;

  frame_state_e state_q;
  frame_state_e state_d;
  logic         frame_err_d;
  ntt_ctrl_t    in_ctrl;
  logic         avail_q;
  ntt_ctrl_t    ctrl_q;
  coef_vec_t    data_q;

  assign in_ctrl = '{sob: in_sob_i, eob: in_eob_i, pbs_id: in_pbs_id_i};

  // Framing check, only on avail beats
  always_comb begin
    state_d     = state_q;
    frame_err_d = 1'b0;
    if (in_avail_i) begin
      case (state_q)
        FRAME_IDLE:     frame_err_d = ~in_sob_i; // Data outside any batch
        FRAME_IN_BATCH: frame_err_d = in_sob_i;  // Batch restarted while open
        default:        frame_err_d = 1'b0;
      endcase
      state_d = in_eob_i ? FRAME_IDLE : FRAME_IN_BATCH; // eob always closes
    end
  end

  always_ff @(posedge clk or negedge rst_n_i) begin
    if (!rst_n_i) begin
      state_q     <= FRAME_IDLE;
      avail_q     <= 1'b0;
      ctrl_q      <= '0;
      frame_err_o <= 1'b0;
    end else begin
      state_q     <= state_d;
      avail_q     <= in_avail_i;
      ctrl_q      <= in_ctrl;
      frame_err_o <= frame_err_d;
    end
  end

  always_ff @(posedge clk) begin
    data_q <= in_data_i;
  end

  assign out_beat_o = '{avail: avail_q, ctrl: ctrl_q, data: data_q};

  // Upstream must only send reduced coefficients
  a_in_canon : assert property (@(posedge clk) disable iff (!rst_n_i)
    in_avail_i |-> vec_is_canon(in_data_i));

endmodule

`default_nettype wire

//--- ntt_gf64_bu_column.sv
/*
 * One radix-2 butterfly column of the 4-point forward NTT.
 * Twiddles are powers of two, one register stage.
 */
`timescale 1ns/1ps
`default_nettype none

`include "ntt_gf64_macros.svh"

module ntt_gf64_bu_column #(
  parameter int STG_ID = 0 // 0: pairs (0,2),(1,3)   1: pairs (0,1),(2,3)
) (
  input  logic                    clk,
  input  logic                    rst_n_i,
  input  ntt_gf64_pkg::ntt_beat_t in_beat_i,
  input  ntt_gf64_pkg::ntt_err_t  in_err_i,
  output ntt_gf64_pkg::ntt_beat_t out_beat_o,
  output ntt_gf64_pkg::ntt_err_t  out_err_o
);
  import ntt_gf64_pkg::*;

  localparam int BU_NB = `NTT_R / 2;
  localparam int DIST  = (STG_ID == 0) ? BU_NB : 1; // Lane distance inside a pair

  coef_vec_t bu_data;
  logic      avail_q;
  ntt_ctrl_t ctrl_q;
  coef_vec_t data_q;
  ntt_err_t  err_q;

  // --------------------
  // Butterflies
  // --------------------
  for (genvar gen_b = 0; gen_b < BU_NB; gen_b++) begin : gen_bu
    localparam int LO      = (STG_ID == 0) ? gen_b : 2 * gen_b;
    localparam int HI      = LO + DIST;
    localparam bit USE_TWD = (STG_ID == 1) && (gen_b == 1); // w_4 on the odd half

    coef_t hi_twd;

    if (USE_TWD) begin : gen_twd
      assign hi_twd = mod_shift_mul(in_beat_i.data[HI], `NTT_W4_SHIFT);
    end else begin : gen_no_twd
      assign hi_twd = in_beat_i.data[HI];
    end

    assign bu_data[LO] = mod_add(in_beat_i.data[LO], hi_twd);
    assign bu_data[HI] = mod_sub(in_beat_i.data[LO], hi_twd);
  end

  // --------------------
  // Output register
  // --------------------
  always_ff @(posedge clk or negedge rst_n_i) begin
    if (!rst_n_i) begin
      avail_q <= 1'b0;
      ctrl_q  <= '0;
      err_q   <= '0;
    end else begin
      avail_q <= in_beat_i.avail;
      ctrl_q  <= in_beat_i.ctrl;
      err_q   <= in_err_i;  // Follows its beat
    end
  end

  always_ff @(posedge clk) begin
    data_q <= bu_data;
  end

  assign out_beat_o = '{avail: avail_q, ctrl: ctrl_q, data: data_q};
  assign out_err_o  = err_q;

  // Canonical in, canonical out through every column
  a_out_canon : assert property (@(posedge clk) disable iff (!rst_n_i)
    out_beat_o.avail |-> vec_is_canon(out_beat_o.data));

endmodule

`default_nettype wire

//--- ntt_gf64_post_process.sv
/*
 * Post-process: lane-wise multiplication by the key with partial
 * reduction, key valid/ready handshake and missing-key error
 */
`timescale 1ns/1ps
`default_nettype none

`include "ntt_gf64_macros.svh"

module ntt_gf64_post_process (
  input  logic                    clk,
  input  logic                    rst_n_i,
  input  ntt_gf64_pkg::ntt_beat_t in_beat_i,
  input  ntt_gf64_pkg::ntt_err_t  in_err_i,
  input  ntt_gf64_pkg::coef_vec_t bsk_i,
  input  logic                    bsk_vld_i,
  output logic                    bsk_rdy_o,
  output ntt_gf64_pkg::ntt_beat_t out_beat_o,
  output ntt_gf64_pkg::ntt_err_t  out_err_o
);
  import ntt_gf64_pkg::*;

  logic      key_miss;
  ntt_err_t  err_d;
  coef_vec_t pp_data;
  logic      avail_q;
  ntt_ctrl_t ctrl_q;
  coef_vec_t data_q;
  ntt_err_t  err_q;

  // --------------------
  // Key handshake
  // --------------------
  assign bsk_rdy_o = in_beat_i.avail;             // Take a key with each beat
  assign key_miss  = in_beat_i.avail & ~bsk_vld_i;
  assign err_d     = in_err_i | (ntt_err_t'(key_miss) << ERR_KEY_MISS);

  // Missing key multiplies by zero
  for (genvar gen_l = 0; gen_l < `NTT_R; gen_l++) begin : gen_lane
    coef_t key;
    prod_t prod;

    assign key           = bsk_vld_i ? bsk_i[gen_l] : '0;
    assign prod          = key * in_beat_i.data[gen_l];
    assign pp_data[gen_l] = mod_fold_prod(prod); // Below 2^64, not yet below p
  end

  // --------------------
  // Output register
  // --------------------
  always_ff @(posedge clk or negedge rst_n_i) begin
    if (!rst_n_i) begin
      avail_q <= 1'b0;
      ctrl_q  <= '0;
      err_q   <= '0;
    end else begin
      avail_q <= in_beat_i.avail;
      ctrl_q  <= in_beat_i.ctrl;
      err_q   <= err_d;
    end
  end

  always_ff @(posedge clk) begin
    data_q <= pp_data;
  end

  assign out_beat_o = '{avail: avail_q, ctrl: ctrl_q, data: data_q};
  assign out_err_o  = err_q;

  // Key source holds its offer until the handshake
  a_bsk_hold : assert property (@(posedge clk) disable iff (!rst_n_i)
    (bsk_vld_i && !bsk_rdy_o) |=> (bsk_vld_i && $stable(bsk_i)));

endmodule

`default_nettype wire

//--- ntt_gf64_reduction.sv
/*
 * Final stage: brings each lane below p, registers the
 * canonical beat and the avail-gated error vector
 */
`timescale 1ns/1ps
`default_nettype none

`include "ntt_gf64_macros.svh"

module ntt_gf64_reduction (
  input  logic                    clk,
  input  logic                    rst_n_i,
  input  ntt_gf64_pkg::ntt_beat_t in_beat_i,
  input  ntt_gf64_pkg::ntt_err_t  in_err_i,
  output ntt_gf64_pkg::ntt_beat_t out_beat_o,
  output ntt_gf64_pkg::ntt_err_t  error_o
);
  import ntt_gf64_pkg::*;

  coef_vec_t red_data;
  logic      avail_q;
  ntt_ctrl_t ctrl_q;
  coef_vec_t data_q;
  ntt_err_t  err_q;

  // Input is below 2^64 < 2p, one subtraction is enough
  for (genvar gen_l = 0; gen_l < `NTT_R; gen_l++) begin : gen_lane
    assign red_data[gen_l] = (in_beat_i.data[gen_l] >= `NTT_PRIME) ?
                             in_beat_i.data[gen_l] - `NTT_PRIME : in_beat_i.data[gen_l];
  end

  always_ff @(posedge clk or negedge rst_n_i) begin
    if (!rst_n_i) begin
      avail_q <= 1'b0;
      ctrl_q  <= '0;
      err_q   <= '0;
    end else begin
      avail_q <= in_beat_i.avail;
      ctrl_q  <= in_beat_i.ctrl;
      err_q   <= in_beat_i.avail ? in_err_i : '0; // Pulse only with a real beat
    end
  end

  always_ff @(posedge clk) begin
    data_q <= red_data;
  end

  assign out_beat_o = '{avail: avail_q, ctrl: ctrl_q, data: data_q};
  assign error_o    = err_q;

  // Upstream flags travel only with a beat
  a_err_with_beat : assert property (@(posedge clk) disable iff (!rst_n_i)
    (in_err_i != '0) |-> in_beat_i.avail);

endmodule

`default_nettype wire

//--- ntt_gf64_core.sv
/*
 * Top of the GF64 4-point forward NTT pipeline.
 * Decode, two butterfly columns, key post-process and final reduction.
 */
`timescale 1ns/1ps
`default_nettype none

`include "ntt_gf64_macros.svh"

module ntt_gf64_core (
  input  logic                     clk,
  input  logic                     rst_n_i,

  input  logic                     in_avail_i,
  input  logic                     in_sob_i,
  input  logic                     in_eob_i,
  input  logic [`NTT_PBS_ID_W-1:0] in_pbs_id_i,
  input  ntt_gf64_pkg::coef_vec_t  in_data_i,

  // Lanes leave as X0, X2, X1, X3
  output logic                     out_avail_o,
  output logic                     out_sob_o,
  output logic                     out_eob_o,
  output logic [`NTT_PBS_ID_W-1:0] out_pbs_id_o,
  output ntt_gf64_pkg::coef_vec_t  out_data_o,

  input  ntt_gf64_pkg::coef_vec_t  bsk_i,
  input  logic                     bsk_vld_i,
  output logic                     bsk_rdy_o,

  output ntt_gf64_pkg::ntt_err_t   error_o
);
  import ntt_gf64_pkg::*;

  ntt_beat_t dec_beat;
  logic      dec_frame_err;
  ntt_err_t  dec_err;
  ntt_beat_t bu0_beat;
  ntt_err_t  bu0_err;
  ntt_beat_t bu1_beat;
  ntt_err_t  bu1_err;
  ntt_beat_t pp_beat;
  ntt_err_t  pp_err;
  ntt_beat_t red_beat;

  assign dec_err = ntt_err_t'(dec_frame_err) << ERR_FRAMING;

  // --------------------
  // Pipeline, 5 cycles
  // --------------------
  ntt_gf64_in_decode ntt_gf64_in_decode (
    .clk         (clk),
    .rst_n_i     (rst_n_i),
    .in_avail_i  (in_avail_i),
    .in_sob_i    (in_sob_i),
    .in_eob_i    (in_eob_i),
    .in_pbs_id_i (in_pbs_id_i),
    .in_data_i   (in_data_i),
    .out_beat_o  (dec_beat),
    .frame_err_o (dec_frame_err)
  );

  ntt_gf64_bu_column #(.STG_ID(0)) ntt_gf64_bu_column_0 (
    .clk        (clk),
    .rst_n_i    (rst_n_i),
    .in_beat_i  (dec_beat),
    .in_err_i   (dec_err),
    .out_beat_o (bu0_beat),
    .out_err_o  (bu0_err)
  );

  ntt_gf64_bu_column #(.STG_ID(1)) ntt_gf64_bu_column_1 (
    .clk        (clk),
    .rst_n_i    (rst_n_i),
    .in_beat_i  (bu0_beat),
    .in_err_i   (bu0_err),
    .out_beat_o (bu1_beat),
    .out_err_o  (bu1_err)
  );

  ntt_gf64_post_process ntt_gf64_post_process (
    .clk        (clk),
    .rst_n_i    (rst_n_i),
    .in_beat_i  (bu1_beat),
    .in_err_i   (bu1_err),
    .bsk_i      (bsk_i),
    .bsk_vld_i  (bsk_vld_i),
    .bsk_rdy_o  (bsk_rdy_o),
    .out_beat_o (pp_beat),
    .out_err_o  (pp_err)
  );

  ntt_gf64_reduction ntt_gf64_reduction (
    .clk        (clk),
    .rst_n_i    (rst_n_i),
    .in_beat_i  (pp_beat),
    .in_err_i   (pp_err),
    .out_beat_o (red_beat),
    .error_o    (error_o)
  );

  assign out_avail_o  = red_beat.avail;
  assign out_sob_o    = red_beat.ctrl.sob;
  assign out_eob_o    = red_beat.ctrl.eob;
  assign out_pbs_id_o = red_beat.ctrl.pbs_id;
  assign out_data_o   = red_beat.data;

endmodule

`default_nettype wire

//--- tb_ntt_gf64_checker.sv
/*
 * Testbench checker: reference model of the key-scaled 4-point NTT,
 * framing rules, output comparison and error counters
 */
`timescale 1ns/1ps
`default_nettype none

`include "ntt_gf64_macros.svh"

module tb_ntt_gf64_checker (
  input  logic                     clk,
  input  logic                     rst_n_i,
  input  logic                     in_avail_i,
  input  logic                     in_sob_i,
  input  logic                     in_eob_i,
  input  logic [`NTT_PBS_ID_W-1:0] in_pbs_id_i,
  input  ntt_gf64_pkg::coef_vec_t  in_data_i,
  input  logic                     out_avail_i,
  input  logic                     out_sob_i,
  input  logic                     out_eob_i,
  input  logic [`NTT_PBS_ID_W-1:0] out_pbs_id_i,
  input  ntt_gf64_pkg::coef_vec_t  out_data_i,
  input  ntt_gf64_pkg::coef_vec_t  bsk_i,
  input  logic                     bsk_vld_i,
  input  logic                     bsk_rdy_i,
  input  ntt_gf64_pkg::ntt_err_t   error_i,
  output int                       data_errs_o,
  output int                       flag_errs_o,
  output int                       timing_errs_o,
  output int                       key_cnt_o,
  output int                       pending_o
);
  import ntt_gf64_pkg::*;

  localparam logic [127:0] P128 = {64'd0, `NTT_PRIME};

  typedef struct packed {
    coef_vec_t   data;      // X in output lane order, key applied once taken
    ntt_ctrl_t   ctrl;
    logic        frame_err;
    logic        key_miss;
    logic [31:0] stamp;     // Entry cycle
  } exp_beat_t;

  exp_beat_t  pend_q[$]; // Entered, key not yet taken
  exp_beat_t  out_q[$];  // Keyed, waiting at the output
  logic       batch_open = 1'b0;
  logic [2:0] avail_hist = '0;
  int         cyc = 0;
  int         data_errs = 0;
  int         flag_errs = 0;
  int         timing_errs = 0;
  int         key_cnt = 0;

  // --------------------
  // Reference arithmetic
  // --------------------
  function automatic coef_t mulmod(input coef_t a, input coef_t b);
    logic [127:0] t;
    t = {64'd0, a} * {64'd0, b};
    t = t % P128;
    return t[63:0];
  endfunction

  function automatic coef_t addmod(input coef_t a, input coef_t b);
    logic [127:0] t;
    t = ({64'd0, a} + {64'd0, b}) % P128;
    return t[63:0];
  endfunction

  // 2 has order 192 mod p
  function automatic coef_t pow2mod(input int e);
    coef_t r;
    r = 64'd1;
    repeat (e % 192) begin
      r = addmod(r, r);
    end
    return r;
  endfunction

  // X_k = sum x_j * w^(jk), stored at the bit-reversed lane of k
  function automatic coef_vec_t fwd_ntt(input coef_vec_t x);
    coef_vec_t y;
    coef_t     acc;
    for (int k = 0; k < `NTT_R; k++) begin
      acc = '0;
      for (int j = 0; j < `NTT_R; j++) begin
        acc = addmod(acc, mulmod(x[j], pow2mod(`NTT_W4_SHIFT * j * k)));
      end
      y[(k % 2) * 2 + k / 2] = acc;
    end
    return y;
  endfunction

  task automatic check_output();
    exp_beat_t e;
    if (out_avail_i) begin
      if (out_q.size() == 0) begin
        timing_errs++;
        $display("Output beat at cycle %0d has no matching input beat", cyc);
      end else begin
        e = out_q.pop_front();
        for (int l = 0; l < `NTT_R; l++) begin
          if (out_data_i[l] !== e.data[l]) begin
            data_errs++;
            $display("FAIL key_scaled_ntt lane %0d: expected %h, actual %h",
                     l, e.data[l], out_data_i[l]);
          end
        end
        if ({out_sob_i, out_eob_i, out_pbs_id_i} !== e.ctrl) begin
          data_errs++;
          $display("FAIL ctrl_passthrough: expected %h, actual %h",
                   e.ctrl, {out_sob_i, out_eob_i, out_pbs_id_i});
        end
        if (error_i[ERR_KEY_MISS] !== e.key_miss) begin
          flag_errs++;
          $display("FAIL key_missing_flag: expected %b, actual %b",
                   e.key_miss, error_i[ERR_KEY_MISS]);
        end
        if (error_i[ERR_FRAMING] !== e.frame_err) begin
          flag_errs++;
          $display("FAIL framing_flag: expected %b, actual %b",
                   e.frame_err, error_i[ERR_FRAMING]);
        end
        if (cyc != e.stamp + 5) begin
          timing_errs++;
          $display("FAIL latency: expected %0d, actual %0d", 5, cyc - e.stamp);
        end
      end
    end else if (error_i != '0) begin
      flag_errs++;
      $display("error_o pulsed at cycle %0d without an output beat", cyc);
    end
  endtask

  task automatic take_key();
    exp_beat_t e;
    coef_vec_t key;
    if (bsk_rdy_i !== avail_hist[2]) begin
      timing_errs++;
      $display("bsk_rdy_o is %b at cycle %0d, three cycles after in_avail_i %b",
               bsk_rdy_i, cyc, avail_hist[2]);
    end
    if (bsk_rdy_i && pend_q.size() != 0) begin
      e          = pend_q.pop_front();
      e.key_miss = ~bsk_vld_i;
      key        = bsk_vld_i ? bsk_i : '0; // Missing key acts as zero
      for (int l = 0; l < `NTT_R; l++) begin
        e.data[l] = mulmod(e.data[l], key[l]);
      end
      out_q.push_back(e);
      if (bsk_vld_i) begin
        key_cnt++;
      end
    end
  endtask

  task automatic record_input();
    exp_beat_t e;
    if (in_avail_i) begin
      e.frame_err = batch_open ? in_sob_i : ~in_sob_i;
      batch_open  = ~in_eob_i;
      e.data      = fwd_ntt(in_data_i);
      e.ctrl      = '{sob: in_sob_i, eob: in_eob_i, pbs_id: in_pbs_id_i};
      e.key_miss  = 1'b0;
      e.stamp     = cyc;
      pend_q.push_back(e);
    end
  endtask

  // Everything is sampled mid-cycle, away from both edges
  always @(negedge clk) begin
    if (rst_n_i !== 1'b1) begin
      pend_q.delete();
      out_q.delete();
      batch_open = 1'b0;
      avail_hist = '0;
      if (out_avail_i || bsk_rdy_i || error_i != '0) begin
        timing_errs++;
        $display("DUT outputs not cleared while reset is asserted");
      end
    end else begin
      cyc++;
      check_output();
      take_key();
      record_input();
      avail_hist = {avail_hist[1:0], in_avail_i};
    end
    pending_o = pend_q.size() + out_q.size();
  end

  assign data_errs_o   = data_errs;
  assign flag_errs_o   = flag_errs;
  assign timing_errs_o = timing_errs;
  assign key_cnt_o     = key_cnt;

endmodule

`default_nettype wire

//--- tb_ntt_gf64.sv
/*
 * Testbench top for the GF64 NTT pipeline: clock, reset, seeded random
 * batches and keys, broken frames, timeout and final report
 */
`timescale 1ns/1ps
`default_nettype none

`include "ntt_gf64_macros.svh"

module tb_ntt_gf64;
  import ntt_gf64_pkg::*;

  localparam int    N_BEATS    = 2000;
  localparam int    MAX_CYCLES = N_BEATS * 2 + 100;
  localparam coef_t PRIME      = `NTT_PRIME;

  logic                     clk;
  logic                     rst_n_i;
  logic                     in_avail_i;
  logic                     in_sob_i;
  logic                     in_eob_i;
  logic [`NTT_PBS_ID_W-1:0] in_pbs_id_i;
  coef_vec_t                in_data_i;
  logic                     out_avail_o;
  logic                     out_sob_o;
  logic                     out_eob_o;
  logic [`NTT_PBS_ID_W-1:0] out_pbs_id_o;
  coef_vec_t                out_data_o;
  coef_vec_t                bsk_i;
  logic                     bsk_vld_i;
  logic                     bsk_rdy_o;
  ntt_err_t                 error_o;

  int          data_errs;
  int          flag_errs;
  int          timing_errs;
  int          key_cnt;
  int          pending;
  int          key_errs = 0;
  int          keys_taken = 0;
  int          beats_sent = 0;
  int          cycle_cnt = 0;
  logic [`NTT_PBS_ID_W-1:0] pbs_id;

  ntt_gf64_core DUT (.*);

  tb_ntt_gf64_checker scoreboard (
    .clk           (clk),
    .rst_n_i       (rst_n_i),
    .in_avail_i    (in_avail_i),
    .in_sob_i      (in_sob_i),
    .in_eob_i      (in_eob_i),
    .in_pbs_id_i   (in_pbs_id_i),
    .in_data_i     (in_data_i),
    .out_avail_i   (out_avail_o),
    .out_sob_i     (out_sob_o),
    .out_eob_i     (out_eob_o),
    .out_pbs_id_i  (out_pbs_id_o),
    .out_data_i    (out_data_o),
    .bsk_i         (bsk_i),
    .bsk_vld_i     (bsk_vld_i),
    .bsk_rdy_i     (bsk_rdy_o),
    .error_i       (error_o),
    .data_errs_o   (data_errs),
    .flag_errs_o   (flag_errs),
    .timing_errs_o (timing_errs),
    .key_cnt_o     (key_cnt),
    .pending_o     (pending)
  );

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  always @(posedge clk) begin
    cycle_cnt++;
    if (cycle_cnt >= MAX_CYCLES) begin
      $display("Timeout after %0d cycles with %0d beats still in flight", cycle_cnt, pending);
      $display("Regression failed");
      $finish;
    end
  end

  // --------------------
  // Stimulus helpers
  // --------------------
  function automatic coef_t rand_coef(input bit edge_mode);
    coef_t v;
    if (edge_mode) begin
      case ($urandom % 6)
        0:       v = '0;
        1:       v = PRIME - 1;
        2:       v = 64'h1_0000_0000;
        3:       v = 64'hFFFF_FFFF;
        4:       v = 64'd1 << ($urandom % 64);
        default: v = PRIME - (64'd1 << ($urandom % 32));
      endcase
    end else begin
      v = {$urandom, $urandom};
    end
    return (v >= PRIME) ? v - PRIME : v;
  endfunction

  function automatic coef_vec_t rand_vec(input bit edge_mode);
    coef_vec_t v;
    for (int l = 0; l < `NTT_R; l++) begin
      v[l] = rand_coef(edge_mode);
    end
    return v;
  endfunction

  task automatic next_cycle();
    @(posedge clk);
    #1;
  endtask

  task automatic send_beat(input logic sob, input logic eob, input bit edge_mode);
    in_avail_i  = 1'b1;
    in_sob_i    = sob;
    in_eob_i    = eob;
    in_pbs_id_i = pbs_id;
    in_data_i   = rand_vec(edge_mode);
    next_cycle();
    in_avail_i  = 1'b0;
    in_sob_i    = 1'b0;
    in_eob_i    = 1'b0;
    beats_sent++;
  endtask

  // kind 1 drops sob on the first beat, kind 2 repeats sob on the last
  task automatic send_batch(input int n, input bit edge_mode, input bit gaps, input int kind);
    logic sob;
    logic eob;
    for (int b = 0; b < n; b++) begin
      sob = (b == 0) && (kind != 1);
      eob = (b == n - 1);
      if (kind == 2 && b == n - 1) begin
        sob = 1'b1;
      end
      send_beat(sob, eob, edge_mode);
      if (gaps && $urandom % 4 == 0) begin
        repeat (1 + $urandom % 3) next_cycle();
      end
    end
    pbs_id++;
  endtask

  // Holds a key until it is taken, drops valid now and then
  task automatic drive_keys();
    logic took;
    forever begin
      @(negedge clk);
      took = bsk_vld_i && bsk_rdy_o;
      next_cycle();
      if (took) begin
        keys_taken++;
      end
      if (took || !bsk_vld_i) begin
        bsk_i     = rand_vec($urandom % 8 == 0);
        bsk_vld_i = ($urandom % 12 != 0);
      end
    end
  endtask

  initial begin
    int n;
    int kind;
    void'($urandom(73400));
    rst_n_i     = 1'b0;
    in_avail_i  = 1'b0;
    in_sob_i    = 1'b0;
    in_eob_i    = 1'b0;
    in_pbs_id_i = '0;
    in_data_i   = '0;
    bsk_i       = '0;
    bsk_vld_i   = 1'b0;
    pbs_id      = '0;
    repeat (5) @(posedge clk);
    #1;
    rst_n_i   = 1'b1;
    bsk_i     = rand_vec(1'b0);
    bsk_vld_i = 1'b1;
    fork
      drive_keys();
    join_none
    repeat (3) next_cycle();

    while (beats_sent < 200) begin       // Edge values with gaps
      send_batch(1 + $urandom % 6, 1'b1, 1'b1, 0);
    end
    while (beats_sent < 800) begin       // Back to back
      send_batch(1 + $urandom % 6, 1'b0, 1'b0, 0);
    end
    while (beats_sent < N_BEATS) begin
      n    = 1 + $urandom % 6;
      kind = ($urandom % 10 == 0) ? 1 + $urandom % 2 : 0;
      if (kind == 2 && n < 2) begin
        n = 2;
      end
      send_batch(n, $urandom % 8 == 0, 1'b1, kind);
    end

    while (pending != 0) begin
      next_cycle();
    end
    repeat (10) next_cycle();

    if (key_cnt != keys_taken) begin
      key_errs++;
      $display("Model counted %0d key handshakes, key driver saw %0d", key_cnt, keys_taken);
    end
    $display("Errors: data %0d, flags %0d, timing %0d, keys %0d over %0d beats",
             data_errs, flag_errs, timing_errs, key_errs, beats_sent);
    if (data_errs + flag_errs + timing_errs + key_errs == 0) begin
      $display("Regression passed");
    end else begin
      $display("Regression failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- tb.f
+incdir+.
ntt_gf64_pkg.sv
ntt_gf64_in_decode.sv
ntt_gf64_bu_column.sv
ntt_gf64_post_process.sv
ntt_gf64_reduction.sv
ntt_gf64_core.sv
tb_ntt_gf64_checker.sv
tb_ntt_gf64.sv
